//--- run.sh
#!/usr/bin/env bash
# Build and run the main CPU glue testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module mainCpuGlueTb --Mdir obj_dir
./obj_dir/VmainCpuGlueTb | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"

//--- tb.f
+incdir+verilog
verilog/sys86Pkg.sv
verilog/cpuClockGen.sv
verilog/mainAddrDecoder.sv
verilog/watchdogIrq.sv
verilog/videoLatchBank.sv
verilog/mainCpuGlue.sv
verification/mainCpuGlue_props.sv
verification/mainCpuGlueTb.sv

//--- verification/mainCpuGlueTb.sv
`timescale 1ns/1ns

`include "sys86_consts.svh"

// Testbench for the main CPU glue chip
module mainCpuGlueTb import sys86Pkg::*; ();

	localparam int WaitLimit = 64;
	localparam int RunLimit = 20000;

	logic clk6M;
	logic rstN;
	logic [15:0] ma;
	logic [7:0] md;
	logic mweN;
	logic vblankN;
	logic spriteCsN;
	logic vram0CsN;
	logic vram1CsN;
	logic eepromCsN;
	logic romCsN;
	logic eClk;
	logic qClk;
	logic mresetN;
	logic mintN;
	planeScrollT plane0;
	planeScrollT plane1;
	planeScrollT plane2;
	planeScrollT plane3;
	logic [`SYS86_BANK_WIDTH-1:0] romBank0;
	logic [`SYS86_BANK_WIDTH-1:0] romBank1;

	// Shadow state of the DUT
	planeScrollT planeExp [4];
	logic [`SYS86_BANK_WIDTH-1:0] bankExp [2];
	int wdogExp;
	logic clrPendExp;
	logic intReqExp;

	// Bookkeeping
	string testName;
	string hungWhat;
	logic hungFlag = 1'b0;
	logic stimDone = 1'b0;
	int testErrs;
	int errCount;
	int testCount;
	int failCount;

	mainCpuGlue dut (.*);

	always #5 clk6M = ~clk6M;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Region of an address from the memory map
	function automatic memRegionE refRegion(input logic [15:0] addr, input logic weN);
		if (addr < 16'h2000) return rgnSprite;
		if (addr < 16'h4000) return rgnVram0;
		if (addr < 16'h6000) return rgnVram1;
		if (addr < 16'h8000) return rgnEeprom;
		if (weN) return rgnRom;
		if (addr < 16'h8800) return rgnWdog;
		if (addr < 16'h9000) return rgnIntAck;
		if (addr >= 16'hD000 && addr < 16'hD800) return rgnLatch0;
		if (addr >= 16'hD800 && addr < 16'hE000) return rgnLatch1;
		return rgnNone;
	endfunction

	// Order is sprite, vram0, vram1, eeprom, rom
	function automatic logic [4:0] refChipSelects(input memRegionE rgn);
		return ~{rgn == rgnSprite, rgn == rgnVram0, rgn == rgnVram1,
			rgn == rgnEeprom, rgn == rgnRom};
	endfunction

	// Field 0 is priority in bits 7..5 plus scroll X bit 8 in bit 0
	function automatic planeScrollT refPlane(input planeScrollT cur, input logic [1:0] field,
		input logic [7:0] data);
		planeScrollT nxt;
		nxt = cur;
		if (field == 2'd0) begin
			nxt.prio = data[7:5];
			nxt.scrollX[8] = data[0];
		end else if (field == 2'd1) begin
			nxt.scrollX[7:0] = data;
		end else if (field == 2'd2) begin
			nxt.scrollY = data;
		end
		return nxt;
	endfunction

	// Count after one vblank edge
	function automatic int refWdog(input int count, input logic clr);
		if (clr || count == `SYS86_WDOG_WRAP) return 0;
		return count + 1;
	endfunction

	task automatic shadowWrite(input logic win, input logic [2:0] ofs, input logic [7:0] data);
		if (ofs == 3'd3) begin
			bankExp[win] = data[`SYS86_BANK_WIDTH-1:0];
		end else if (ofs != 3'd7) begin
			planeExp[{win, ofs[2]}] = refPlane(planeExp[{win, ofs[2]}], ofs[1:0], data);
		end
	endtask

	//////////////////////////////
	// Reporting
	//////////////////////////////
	task automatic reportMismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERROR %s %s: expected %0h, actual %0h", testName, what, exp, act);
		testErrs++;
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrs = 0;
	endtask

	task automatic finishTest;
		$display("%-16s %s (%0d mismatches)", testName, testErrs == 0 ? "ok" : "FAILED", testErrs);
		testCount++;
		errCount += testErrs;
		if (testErrs != 0) failCount++;
	endtask

	task automatic checkIrq(input string what);
		if (mintN !== ~intReqExp) reportMismatch(what, 32'(~intReqExp), 32'(mintN));
	endtask

	//////////////////////////////
	// Bus and frame drivers
	//////////////////////////////

	// Waits at falling edges for a given E/Q level pair
	task automatic waitPattern(input logic e, input logic q, input string what);
		int n;
		n = 0;
		while ((eClk !== e || qClk !== q) && n < WaitLimit) begin
			@(negedge clk6M);
			n++;
		end
		if (eClk !== e || qClk !== q) begin
			hungFlag = 1'b1;
			hungWhat = what;
		end
	endtask

	// E high with Q low is the quarter in which cpuEn is set
	task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
		waitPattern(1'b1, 1'b0, "a CPU bus cycle");
		ma = addr;
		md = data;
		mweN = 1'b0;
		@(negedge clk6M);
		mweN = 1'b1;
		case (refRegion(addr, 1'b0))
			rgnWdog: clrPendExp = 1'b1;
			rgnIntAck: intReqExp = 1'b0;
			rgnLatch0: shadowWrite(1'b0, addr[2:0], data);
			rgnLatch1: shadowWrite(1'b1, addr[2:0], data);
			default: ;
		endcase
	endtask

	// Edge is seen one clock after the drive and the counter moves one clock later
	task automatic frameEdge;
		vblankN = 1'b0;
		repeat (3) @(negedge clk6M);
		wdogExp = refWdog(wdogExp, clrPendExp);
		clrPendExp = 1'b0;
		intReqExp = 1'b1;
		vblankN = 1'b1;
		repeat (3) @(negedge clk6M);
	endtask

	// Compares chip selects and latch outputs with the model on every clock
	always @(posedge clk6M) begin : compareOutputs
		logic [4:0] expCs;
		expCs = refChipSelects(refRegion(ma, mweN));
		if (rstN) begin
			if ({spriteCsN, vram0CsN, vram1CsN, eepromCsN, romCsN} !== expCs)
				reportMismatch($sformatf("chip selects @%4h", ma), 32'(expCs),
					32'({spriteCsN, vram0CsN, vram1CsN, eepromCsN, romCsN}));
			if (plane0 !== planeExp[0]) reportMismatch("plane0", 32'(planeExp[0]), 32'(plane0));
			if (plane1 !== planeExp[1]) reportMismatch("plane1", 32'(planeExp[1]), 32'(plane1));
			if (plane2 !== planeExp[2]) reportMismatch("plane2", 32'(planeExp[2]), 32'(plane2));
			if (plane3 !== planeExp[3]) reportMismatch("plane3", 32'(planeExp[3]), 32'(plane3));
			if ({romBank1, romBank0} !== {bankExp[1], bankExp[0]})
				reportMismatch("ROM banks", 32'({bankExp[1], bankExp[0]}), 32'({romBank1, romBank0}));
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin : stimulus
		logic win;
		logic [2:0] ofs;
		int ph;
		logic expE;
		logic expQ;
		clk6M = 1'b0;
		rstN = 1'b0;
		ma = '0;
		md = '0;
		mweN = 1'b1;
		vblankN = 1'b1;
		void'($urandom(84967));
		for (int p = 0; p < 4; p++) planeExp[p] = '0;
		bankExp[0] = '0;
		bankExp[1] = '0;
		wdogExp = 0;
		clrPendExp = 1'b0;
		intReqExp = 1'b0;

		// Idle levels while reset is held
		startTest("reset");
		repeat (5) @(negedge clk6M);
		if ({eClk, qClk, mresetN, mintN} !== 4'b0011)
			reportMismatch("E,Q,mresetN,mintN", 32'h3, 32'({eClk, qClk, mresetN, mintN}));
		rstN = 1'b1;
		@(negedge clk6M);
		finishTest();

		// Four-phase E/Q pattern from phase 1 on
		startTest("cpu clocks");
		waitPattern(1'b0, 1'b1, "Q to rise after reset");
		for (int i = 0; i < 40; i++) begin
			ph = (1 + i) % 4;
			expE = ph >= 2;
			expQ = ph == 1 || ph == 2;
			if ({eClk, qClk} !== {expE, expQ})
				reportMismatch($sformatf("E,Q phase %0d", ph), 32'({expE, expQ}), 32'({eClk, qClk}));
			@(negedge clk6M);
		end
		finishTest();

		// The compare process checks each read address
		startTest("chip selects");
		for (int i = 0; i < 200; i++) begin
			ma = 16'($urandom);
			md = 8'($urandom);
			@(negedge clk6M);
		end
		finishTest();

		startTest("latches");
		for (int i = 0; i < 64; i++) begin
			win = 1'($urandom);
			ofs = 3'($urandom);
			busWrite({4'hD, win, 8'($urandom), ofs}, 8'($urandom));
		end
		// Offset 7 in both windows must leave everything alone
		busWrite(16'hD007, 8'hFF);
		busWrite(16'hD80F, 8'hFF);
		repeat (2) @(negedge clk6M);
		finishTest();

		// Count runs 1..10 and wraps on frame 11 with reset low for 8..10
		startTest("watchdog reset");
		for (int f = 1; f <= 11; f++) begin
			frameEdge();
			if (mresetN !== (wdogExp < 8))
				reportMismatch($sformatf("mresetN frame %0d", f), 32'(wdogExp < 8), 32'(mresetN));
		end
		finishTest();

		startTest("watchdog clear");
		for (int f = 1; f <= 20; f++) begin
			busWrite({5'b10000, 11'($urandom)}, 8'($urandom));
			frameEdge();
			if (mresetN !== 1'b1)
				reportMismatch($sformatf("mresetN frame %0d", f), 32'h1, 32'(mresetN));
		end
		finishTest();

		startTest("interrupt");
		busWrite({5'b10001, 11'($urandom)}, 8'($urandom));
		checkIrq("mintN after ack");
		frameEdge();
		checkIrq("mintN after vblank");
		// Latch, watchdog, unmapped and VRAM writes
		busWrite({4'hD, 1'b0, 8'($urandom), 3'd1}, 8'($urandom));
		busWrite({5'b10000, 11'($urandom)}, 8'($urandom));
		busWrite({5'b10010, 11'($urandom)}, 8'($urandom));
		busWrite({3'b001, 13'($urandom)}, 8'($urandom));
		checkIrq("mintN after other writes");
		busWrite({5'b10001, 11'($urandom)}, 8'($urandom));
		checkIrq("mintN after second ack");
		// Drop vblank in phase 2 so the edge lands in the ack's bus cycle
		waitPattern(1'b1, 1'b1, "phase 2 of E");
		vblankN = 1'b0;
		@(negedge clk6M);
		if ({eClk, qClk} !== 2'b10) reportMismatch("bus cycle alignment", 32'h2, 32'({eClk, qClk}));
		ma = {5'b10001, 11'($urandom)};
		mweN = 1'b0;
		@(negedge clk6M);
		mweN = 1'b1;
		wdogExp = refWdog(wdogExp, clrPendExp);
		clrPendExp = 1'b0;
		// New frame wins over the ack
		intReqExp = 1'b1;
		repeat (2) @(negedge clk6M);
		vblankN = 1'b1;
		repeat (3) @(negedge clk6M);
		checkIrq("mintN after ack on vblank");
		finishTest();

		stimDone = 1'b1;
	end

	// Ends the run after the stimulus finishes or stalls
	initial begin : finalReport
		int cycles;
		cycles = 0;
		while (!stimDone && !hungFlag && cycles < RunLimit) begin
			@(posedge clk6M);
			cycles++;
		end
		if (hungFlag) begin
			$display("Timed out waiting for %s in test %s", hungWhat, testName);
		end else if (!stimDone) begin
			$display("Run did not complete within %0d clock cycles", RunLimit);
		end else begin
			$display("%0d tests, %0d failed, %0d mismatches", testCount, failCount, errCount);
		end
		if (stimDone && !hungFlag && failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- verification/mainCpuGlue_props.sv
`timescale 1ns/1ns

// Clock, reset and interrupt properties of the main CPU glue
module mainCpuGlueProps (
	input logic clk6M,
	input logic rstN,
	input logic eClk,
	input logic qClk,
	input logic intAck,
	input logic mresetN,
	input logic mintN
);

	// Q moves one clk6M cycle ahead of every E transition
	qLeadsE: assert property (@(posedge clk6M) disable iff (!rstN)
		$changed(eClk) |-> ($past(qClk) != $past(qClk, 2)))
		else $error("qClk did not change one cycle before eClk");

	// Board reset and interrupt idle high out of reset
	resetIdle: assert property (@(posedge clk6M) !rstN |=> (mintN && mresetN))
		else $error("mintN or mresetN low after reset");

	// Only an acknowledge write releases the interrupt
	intRelease: assert property (@(posedge clk6M) disable iff (!rstN)
		$rose(mintN) |-> $past(intAck))
		else $error("mintN rose without an acknowledge write");

endmodule

bind mainCpuGlue mainCpuGlueProps props (
	.clk6M(clk6M),
	.rstN(rstN),
	.eClk(eClk),
	.qClk(qClk),
	.intAck(intAck),
	.mresetN(mresetN),
	.mintN(mintN)
);

//--- verilog/cpuClockGen.sv
`timescale 1ns/1ns

// 6809 E/Q clock pair derived from the 6 MHz pixel clock
// Phase  E  Q  En
//   0    0  0  0
//   1    0  1  0
//   2    1  1  0
//   3    1  0  1
module cpuClockGen (
	input  logic clk6M,
	input  logic rstN,
	output logic eClk,
	output logic qClk,
	output logic cpuEn
);

	logic [1:0] phase;
	logic [1:0] phaseNext;

	// Free-running quarter counter
	assign phaseNext = phase + 2'd1;

	//////////////////////////////
	// Phase counter
	//////////////////////////////
	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			phase <= 2'd0;
		end else begin
			phase <= phaseNext;
		end
	end

	//////////////////////////////
	// Registered clock outputs
	//////////////////////////////

	// Outputs are decoded from the next phase so they line up with the
	// counter and leave the flops without decode glitches
	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			eClk <= 1'b0;
			qClk <= 1'b0;
			cpuEn <= 1'b0;
		end else begin
			// E high in the upper half
			eClk <= phaseNext[1];
			// Q leads E by a quarter
			qClk <= phaseNext[1] ^ phaseNext[0];
			// Bus cycle completes at the end of E high
			cpuEn <= &phaseNext;
		end
	end

endmodule

//--- verilog/mainAddrDecoder.sv
`timescale 1ns/1ns

// Main CPU address decoder
// Chip selects follow the address only, write strobes need a bus cycle
module mainAddrDecoder import sys86Pkg::*; (
	input  logic [15:11] ma,
	input  logic mweN,
	input  logic cpuEn,
	output logic spriteCsN,
	output logic vram0CsN,
	output logic vram1CsN,
	output logic eepromCsN,
	output logic romCsN,
	output logic wdogClr,
	output logic intAck,
	output logic latchWr0,
	output logic latchWr1
);

	memRegionE region;
	logic busWr;

	// One accepted write per E cycle
	assign busWr = cpuEn & ~mweN;

	//////////////////////////////
	// Region decode
	//////////////////////////////
	always_comb begin
		case (ma[15:13])
			3'b000: region = rgnSprite;
			3'b001: region = rgnVram0;
			3'b010: region = rgnVram1;
			3'b011: region = rgnEeprom;
			default: begin
				// Upper half is ROM on reads, registers on writes
				if (mweN) begin
					region = rgnRom;
				end else begin
					case (ma[14:11])
						4'b0000: region = rgnWdog;
						4'b0001: region = rgnIntAck;
						4'b1010: region = rgnLatch0;
						4'b1011: region = rgnLatch1;
						default: region = rgnNone;
					endcase
				end
			end
		endcase
	end

	//////////////////////////////
	// Chip selects, active low
	//////////////////////////////
	assign spriteCsN = region != rgnSprite;
	assign vram0CsN = region != rgnVram0;
	assign vram1CsN = region != rgnVram1;
	assign eepromCsN = region != rgnEeprom;
	// ROM is deselected on any write
	assign romCsN = region != rgnRom;

	//////////////////////////////
	// Internal write strobes
	//////////////////////////////

	// Sampled by the clk6M edge at the end of the bus cycle
	assign wdogClr = busWr & (region == rgnWdog);
	assign intAck = busWr & (region == rgnIntAck);
	// Scroll, priority and bank windows
	assign latchWr0 = busWr & (region == rgnLatch0);
	assign latchWr1 = busWr & (region == rgnLatch1);

endmodule

//--- verilog/mainCpuGlue.sv
`timescale 1ns/1ns

`include "sys86_consts.svh"

// Main CPU glue: clocks, decode, watchdog and video latches
module mainCpuGlue import sys86Pkg::*; (
	input  logic clk6M,
	input  logic rstN,
	input  logic [15:0] ma,
	input  logic [7:0] md,
	input  logic mweN,
	input  logic vblankN,
	output logic spriteCsN,
	output logic vram0CsN,
	output logic vram1CsN,
	output logic eepromCsN,
	output logic romCsN,
	output logic eClk,
	output logic qClk,
	output logic mresetN,
	output logic mintN,
	output planeScrollT plane0,
	output planeScrollT plane1,
	output planeScrollT plane2,
	output planeScrollT plane3,
	output logic [`SYS86_BANK_WIDTH-1:0] romBank0,
	output logic [`SYS86_BANK_WIDTH-1:0] romBank1
);

	// Bus cycle enable
	logic cpuEn;
	// Decoded write strobes
	logic wdogClr;
	logic intAck;
	logic latchWr0;
	logic latchWr1;

	//////////////////////////////
	// CPU clocks
	//////////////////////////////
	cpuClockGen clockGen (
		.clk6M(clk6M),
		.rstN(rstN),
		.eClk(eClk),
		.qClk(qClk),
		.cpuEn(cpuEn)
	);

	//////////////////////////////
	// Address decode
	//////////////////////////////
	mainAddrDecoder addrDecoder (
		.ma(ma[15:11]),
		.mweN(mweN),
		.cpuEn(cpuEn),
		.spriteCsN(spriteCsN),
		.vram0CsN(vram0CsN),
		.vram1CsN(vram1CsN),
		.eepromCsN(eepromCsN),
		.romCsN(romCsN),
		.wdogClr(wdogClr),
		.intAck(intAck),
		.latchWr0(latchWr0),
		.latchWr1(latchWr1)
	);

	// Watchdog and frame interrupt
	watchdogIrq wdog (
		.clk6M(clk6M),
		.rstN(rstN),
		.vblankN(vblankN),
		.wdogClr(wdogClr),
		.intAck(intAck),
		.mresetN(mresetN),
		.mintN(mintN)
	);

	// Low address bits select the register inside a window
	videoLatchBank latches (
		.clk6M(clk6M),
		.rstN(rstN),
		.latchWr0(latchWr0),
		.latchWr1(latchWr1),
		.addrLow(ma[2:0]),
		.md(md),
		.plane0(plane0),
		.plane1(plane1),
		.plane2(plane2),
		.plane3(plane3),
		.romBank0(romBank0),
		.romBank1(romBank1)
	);

endmodule

//--- verilog/sys86Pkg.sv
package sys86Pkg;

`include "sys86_consts.svh"

	//////////////////////////////
	// Background plane settings
	//////////////////////////////

	// 20 bits per plane
	// Priority sits on top so a plane compares by priority first
	typedef struct packed {
		logic [`SYS86_PRIO_WIDTH-1:0] prio;
		logic [`SYS86_SCROLLX_WIDTH-1:0] scrollX;
		logic [`SYS86_SCROLLY_WIDTH-1:0] scrollY;
	} planeScrollT;

	//////////////////////////////
	// Main CPU address regions
	//////////////////////////////

	// Read/write memory below 8000h, write-only registers above it
	typedef enum logic [3:0] {
		// 0000h-1FFFh
		rgnSprite,
		// 2000h-3FFFh
		rgnVram0,
		// 4000h-5FFFh
		rgnVram1,
		// 6000h-7FFFh
		rgnEeprom,
		// 8000h-FFFFh, reads only
		rgnRom,
		// 8000h-87FFh write
		rgnWdog,
		// 8800h-8FFFh write
		rgnIntAck,
		// D000h-D7FFh write
		rgnLatch0,
		// D800h-DFFFh write
		rgnLatch1,
		// Any other write above 8000h
		rgnNone
	} memRegionE;

endpackage

//--- verilog/sys86_consts.svh
`ifndef SYS86_CONSTS_SVH
`define SYS86_CONSTS_SVH

// Watchdog counter, clocked by vblank edges
`define SYS86_WDOG_WIDTH 4
// Count that wraps back to zero
`define SYS86_WDOG_WRAP 10

// ROM bank select width
`define SYS86_BANK_WIDTH 3

// Plane field widths
`define SYS86_PRIO_WIDTH 3
`define SYS86_SCROLLX_WIDTH 9
`define SYS86_SCROLLY_WIDTH 8

//////////////////////////////
// Latch window offsets
//////////////////////////////
// Field offsets inside one plane group (0..2 or 4..6)
`define SYS86_LATCH_OFS_PRIO 2'd0
`define SYS86_LATCH_OFS_XLO 2'd1
`define SYS86_LATCH_OFS_Y 2'd2
// Full offsets within a window
`define SYS86_LATCH_OFS_BANK 3'd3
`define SYS86_LATCH_OFS_NONE 3'd7
// Address bit that picks the second plane of a window
`define SYS86_LATCH_PLANE_SEL 2
// Data bits for offset 0: priority on top, scroll X bit 8 at the bottom
`define SYS86_PRIO_MSB 7
`define SYS86_XHI_BIT 0

`endif

//--- verilog/videoLatchBank.sv
`timescale 1ns/1ns

`include "sys86_consts.svh"

// Scroll, priority and ROM bank latches for the four background planes
// Window 0 drives planes 0/1 and bank 0, window 1 drives planes 2/3 and bank 1
module videoLatchBank import sys86Pkg::*; (
	input  logic clk6M,
	input  logic rstN,
	input  logic latchWr0,
	input  logic latchWr1,
	input  logic [2:0] addrLow,
	input  logic [7:0] md,
	output planeScrollT plane0,
	output planeScrollT plane1,
	output planeScrollT plane2,
	output planeScrollT plane3,
	output logic [`SYS86_BANK_WIDTH-1:0] romBank0,
	output logic [`SYS86_BANK_WIDTH-1:0] romBank1
);

	planeScrollT planeReg [4];
	logic [`SYS86_BANK_WIDTH-1:0] bankReg [2];
	logic winWr;
	logic [1:0] planeIdx;

	// Merge one data byte into a plane, by field offset
	function automatic planeScrollT loadField(
		input planeScrollT cur,
		input logic [1:0] field,
		input logic [7:0] data
	);
		planeScrollT nxt;
		nxt = cur;
		case (field)
			`SYS86_LATCH_OFS_PRIO: begin
				nxt.prio = data[`SYS86_PRIO_MSB -: `SYS86_PRIO_WIDTH];
				// Ninth scroll X bit shares the priority byte
				nxt.scrollX[`SYS86_SCROLLX_WIDTH-1] = data[`SYS86_XHI_BIT];
			end
			`SYS86_LATCH_OFS_XLO: begin
				nxt.scrollX[`SYS86_SCROLLX_WIDTH-2:0] = data;
			end
			`SYS86_LATCH_OFS_Y: begin
				nxt.scrollY = data;
			end
			default: begin
				nxt = cur;
			end
		endcase
		return nxt;
	endfunction

	// The two windows are mutually exclusive in the decoder
	assign winWr = latchWr0 | latchWr1;
	// Window picks the pair, offset bit 2 picks the plane in it
	assign planeIdx = {latchWr1, addrLow[`SYS86_LATCH_PLANE_SEL]};

	//////////////////////////////
	// Latch registers
	//////////////////////////////
	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			for (int p = 0; p < 4; p++) begin
				planeReg[p] <= '0;
			end
			bankReg[0] <= '0;
			bankReg[1] <= '0;
		end else if (winWr) begin
			if (addrLow == `SYS86_LATCH_OFS_BANK) begin
				bankReg[latchWr1] <= md[`SYS86_BANK_WIDTH-1:0];
			end else if (addrLow != `SYS86_LATCH_OFS_NONE) begin
				planeReg[planeIdx] <= loadField(planeReg[planeIdx], addrLow[1:0], md);
			end
			// Offset 7 has no register behind it
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////
	assign plane0 = planeReg[0];
	assign plane1 = planeReg[1];
	assign plane2 = planeReg[2];
	assign plane3 = planeReg[3];
	assign romBank0 = bankReg[0];
	assign romBank1 = bankReg[1];

endmodule

//--- verilog/watchdogIrq.sv
`timescale 1ns/1ns

`include "sys86_consts.svh"

// Vblank watchdog and per-frame main CPU interrupt
module watchdogIrq (
	input  logic clk6M,
	input  logic rstN,
	input  logic vblankN,
	input  logic wdogClr,
	input  logic intAck,
	output logic mresetN,
	output logic mintN
);

	localparam logic [`SYS86_WDOG_WIDTH-1:0] WrapCount = `SYS86_WDOG_WRAP;

	logic vblankSample;
	logic vblankPrev;
	logic vblankEdge;
	logic clrPending;
	logic [`SYS86_WDOG_WIDTH-1:0] wdogCount;
	logic intReq;

	//////////////////////////////
	// Vblank edge detect
	//////////////////////////////

	// Vblank is a data input here, never a clock
	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			// Idle high so reset release gives no false edge
			vblankSample <= 1'b1;
			vblankPrev <= 1'b1;
		end else begin
			vblankSample <= vblankN;
			vblankPrev <= vblankSample;
		end
	end

	// Start of vblank, one cycle wide
	assign vblankEdge = ~vblankSample & vblankPrev;

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	// A clear write arms the flag, the next frame edge consumes it
	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			clrPending <= 1'b0;
			wdogCount <= '0;
		end else if (vblankEdge) begin
			if (clrPending || wdogCount == WrapCount) begin
				wdogCount <= '0;
			end else begin
				wdogCount <= wdogCount + 1'b1;
			end
			// A clear landing on the edge itself counts for the next frame
			clrPending <= wdogClr;
		end else if (wdogClr) begin
			clrPending <= 1'b1;
		end
	end

	// Board reset while the top bit is set, counts 8..10
	assign mresetN = ~wdogCount[`SYS86_WDOG_WIDTH-1];

	//////////////////////////////
	// Frame interrupt
	//////////////////////////////
	always_ff @(posedge clk6M) begin
		if (!rstN) begin
			intReq <= 1'b0;
		end else if (vblankEdge) begin
			// New frame beats a simultaneous acknowledge
			intReq <= 1'b1;
		end else if (intAck) begin
			intReq <= 1'b0;
		end
	end

	// Level request, held until software acknowledges
	assign mintN = ~intReq;

endmodule
